/* project.f */
+incdir+verilog
verilog/sensor_pkg.sv
verilog/spi_cfg_if.sv
verilog/frame_gate.sv
verilog/capture_ctrl.sv
verilog/config_table.sv
verilog/spi_config.sv
verilog/sensor_capture_top.sv
test/sensor_capture_chk.sv
test/tb_sensor_capture.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sensor capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_sensor_capture --Mdir obj_dir -f project.f; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_sensor_capture 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
   exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

/* test/sensor_capture_chk.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module sensor_capture_chk
(
   input logic clk_80,
   input logic frame_valid,
   input logic pix_valid,
   input logic lval,
   input logic sel_fval,
   input logic overflow,
   input logic spi_en
);

   localparam int EN_CYC = `SPI_W * `SPI_DIV;

   // Cycles spent so far in the current enable window
   logic [7:0] en_len;

   // One flag per property, summed for the testbench
   bit   pix_err = 1'b0;
   bit   ovf_err = 1'b0;
   bit   en_err  = 1'b0;
   logic failed;

   assign failed = pix_err | ovf_err | en_err;

   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         en_len <= '0;
      end
      else if (spi_en)
      begin
         en_len <= en_len + 8'd1;
      end
      else
      begin
         en_len <= '0;
      end
   end

   // Strobe only inside a line of the selected frame
   pix_qual: assert property (@(posedge clk_80) disable iff (!frame_valid)
      pix_valid |-> (lval && sel_fval))
   else
   begin
      pix_err = 1'b1;
      $error("pix_valid high without lval and sel_fval");
   end

   // Sticky flag, only reset clears it
   ovf_sticky: assert property (@(posedge clk_80) disable iff (!frame_valid)
      !$fell(overflow))
   else
   begin
      ovf_err = 1'b1;
      $error("overflow dropped while out of reset");
   end

   // Window never longer than one word
   en_max: assert property (@(posedge clk_80) disable iff (!frame_valid)
      spi_en |-> (en_len < 8'(EN_CYC)))
   else
   begin
      en_err = 1'b1;
      $error("spi_en window too long");
   end

   // and never shorter
   en_exact: assert property (@(posedge clk_80) disable iff (!frame_valid)
      $fell(spi_en) |-> (en_len == 8'(EN_CYC)))
   else
   begin
      en_err = 1'b1;
      $error("spi_en window too short");
   end

endmodule

// Capture side, SPI enable tied off
bind capture_ctrl sensor_capture_chk i_capture_chk
(
   .clk_80      (clk_80),
   .frame_valid (frame_valid),
   .pix_valid   (pix_valid),
   .lval        (lval),
   .sel_fval    (sel_fval),
   .overflow    (overflow),
   .spi_en      (1'b0)
);

// SPI side, capture signals tied off
bind spi_config sensor_capture_chk i_spi_chk
(
   .clk_80      (clk_80),
   .frame_valid (frame_valid),
   .pix_valid   (1'b0),
   .lval        (1'b0),
   .sel_fval    (1'b0),
   .overflow    (1'b0),
   .spi_en      (spi_en)
);

/* test/tb_sensor_capture.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module tb_sensor_capture;

   localparam int CLK_PER   = 4;
   localparam int DRV_DLY   = 1;
   localparam int N_FRAMES  = 18;
   localparam int MAX_LINES = 5;
   localparam int MAX_PIX   = 16;
   // Worst case frame, blanking included
   localparam int FRAME_MAX = 4 + MAX_LINES * (MAX_PIX + 6) + 6;
   // Default word plus the longest table pass
   localparam int MAX_WORDS = 8;
   localparam int WATCH_CYC = 2 * N_FRAMES * FRAME_MAX + 80 * MAX_WORDS + 600;

   logic                clk_80;
   logic                frame_valid;
   logic                fval;
   logic                lval;
   logic [`PIX_W-1:0]   data_image;
   logic                read_open;
   logic                fifo_full;
   logic                host_wr;
   logic [`HOST_AW-1:0] host_addr;
   logic [`BYTE_W-1:0]  host_data;
   logic [`BYTE_W-1:0]  pix_data;
   logic                pix_valid;
   logic                overflow;
   logic                spi_en;
   logic                spi_clk;
   logic                spi_dat;
   logic                sensor_rst_n;

   integer seed = 32'hf11f_ba82;

   // Reference model state
   int                frame_num;
   bit                model_armed;
   bit                full_en;
   bit                full_prev;
   logic              ovf_exp;
   logic              rst_exp;
   logic [`SPI_W-1:0] exp_tbl [`NUM_REGS];
   logic [`SPI_W-1:0] exp_q [$];

   // Words seen on the SPI pins
   logic [`SPI_W-1:0] rx_q [$];
   logic [`SPI_W-1:0] rx_word;
   int                rx_bits;

   sensor_capture_top i_sensor_capture_top
   (
      .clk_80       (clk_80),
      .frame_valid  (frame_valid),
      .fval         (fval),
      .lval         (lval),
      .data_image   (data_image),
      .read_open    (read_open),
      .fifo_full    (fifo_full),
      .host_wr      (host_wr),
      .host_addr    (host_addr),
      .host_data    (host_data),
      .pix_data     (pix_data),
      .pix_valid    (pix_valid),
      .overflow     (overflow),
      .spi_en       (spi_en),
      .spi_clk      (spi_clk),
      .spi_dat      (spi_dat),
      .sensor_rst_n (sensor_rst_n)
   );

   initial clk_80 = 1'b0;
   always #(CLK_PER / 2) clk_80 = ~clk_80;

   function automatic int rnd(input int n);
      return {$random(seed)} % n;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
      if (actv !== expv)
      begin
         fail_run($sformatf("FAIL at %0t ns: %s expected 0x%0h, actual 0x%0h",
                            $time, name, expv, actv));
      end
   endtask

   // Single-cycle host register write
   task automatic host_write(input logic [`HOST_AW-1:0] addr, input logic [`BYTE_W-1:0] data);
      @(posedge clk_80);
      #DRV_DLY;
      host_wr   = 1'b1;
      host_addr = addr;
      host_data = data;
      @(posedge clk_80);
      #DRV_DLY;
      host_wr = 1'b0;
   endtask

   // No traffic for two word times after a pass
   task automatic quiet_check();
      repeat (2 * `SPI_W * `SPI_DIV)
      begin
         @(negedge clk_80);
         check("spi_en", 32'(1'b0), 32'(spi_en));
         check("sensor_rst_n", 32'(1'b1), 32'(sensor_rst_n));
      end
   endtask

   // Wait for n words and the idle sender, then compare with exp_q
   task automatic run_config(input int n);
      int cyc;
      cyc = 0;
      while (rx_q.size() < n)
      begin
         @(negedge clk_80);
         check("sensor_rst_n", 32'(rst_exp), 32'(sensor_rst_n));
         cyc++;
         if (cyc > 80 * n + 40)
         begin
            fail_run("Timeout waiting for the SPI configuration words");
         end
      end
      while (spi_en !== 1'b0)
      begin
         @(negedge clk_80);
         cyc++;
         if (cyc > 80 * n + 40)
         begin
            fail_run("Timeout waiting for spi_en to drop after the last word");
         end
      end
      // Sensor leaves reset with the first finished pass
      rst_exp = 1'b1;
      check("sensor_rst_n", 32'(1'b1), 32'(sensor_rst_n));
      quiet_check();
      check("spi word count", 32'(n), 32'(rx_q.size()));
      for (int i = 0; i < n; i++)
      begin
         check("spi word", 32'(exp_q[i]), 32'(rx_q[i]));
      end
      rx_q.delete();
      exp_q.delete();
   endtask

   // One clock of sensor input, output checked at the falling edge
   task automatic pixel_cycle(input logic fv, input logic lv, input logic [`PIX_W-1:0] d,
                              input bit cap, input logic ff);
      logic              exp_v;
      logic [`BYTE_W-1:0] exp_byte;
      @(posedge clk_80);
      #DRV_DLY;
      if (full_prev)
      begin
         ovf_exp = 1'b1;
      end
      fval       = fv;
      lval       = lv;
      data_image = d;
      fifo_full  = ff;
      full_prev  = ff & lv & cap;
      exp_v      = cap & fv & lv;
      // Top data bits moved down, then inverted
      exp_byte   = `BYTE_W'(~(d >> (`PIX_W - `BYTE_W)));
      @(negedge clk_80);
      check("pix_valid", 32'(exp_v), 32'(pix_valid));
      if (exp_v)
      begin
         check("pix_data", 32'(exp_byte), 32'(pix_data));
      end
      check("overflow", 32'(ovf_exp), 32'(overflow));
   endtask

   task automatic set_open(input logic v);
      @(posedge clk_80);
      #DRV_DLY;
      read_open   = v;
      model_armed = v;
      repeat (4)
      begin
         pixel_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0);
      end
   endtask

   // One frame of random lines, capture predicted from frame number
   task automatic run_frame();
      int   lines;
      int   len;
      bit   cap;
      logic ff;
      frame_num++;
      cap = model_armed && (frame_num % `FRAME_DECIM == 1);
      if (cap)
      begin
         model_armed = 1'b0;
      end
      // lval quiet after the rising fval edge
      repeat (4)
      begin
         pixel_cycle(1'b1, 1'b0, `PIX_W'(rnd(1024)), cap, 1'b0);
      end
      lines = 1 + rnd(MAX_LINES);
      for (int l = 0; l < lines; l++)
      begin
         len = 1 + rnd(MAX_PIX);
         for (int p = 0; p < len; p++)
         begin
            ff = full_en && ((l == 0 && p == 0) || rnd(8) == 0);
            pixel_cycle(1'b1, 1'b1, `PIX_W'(rnd(1024)), cap, ff);
         end
         // Line blanking, also covers the gap before fval falls
         repeat (4 + rnd(3))
         begin
            pixel_cycle(1'b1, 1'b0, `PIX_W'(rnd(1024)), cap, 1'b0);
         end
      end
      repeat (6)
      begin
         pixel_cycle(1'b0, 1'b0, `PIX_W'(rnd(1024)), cap, 1'b0);
      end
   endtask

   // SPI monitor, data taken on the rising spi_clk
   always @(posedge spi_clk)
   begin
      if (spi_en)
      begin
         rx_word = {rx_word[`SPI_W-2:0], spi_dat};
         rx_bits++;
         if (rx_bits == `SPI_W)
         begin
            rx_q.push_back(rx_word);
            rx_bits = 0;
         end
      end
   end

   // Bound checkers raise a flag on any assertion failure
   always @(negedge clk_80)
   begin
      if (i_sensor_capture_top.i_capture_ctrl.i_capture_chk.failed
          || i_sensor_capture_top.i_spi_config.i_spi_chk.failed)
      begin
         fail_run("A bound assertion in the checker failed");
      end
   end

   // Watchdog sized from the frame and word budget
   initial
   begin
      #(WATCH_CYC * CLK_PER);
      fail_run("Watchdog expired before the test sequence finished");
   end

   initial
   begin
      int                 cnt;
      logic [`BYTE_W-1:0] a;
      logic [`BYTE_W-1:0] v;
      frame_valid = 1'b0;
      fval        = 1'b0;
      lval        = 1'b0;
      data_image  = '0;
      read_open   = 1'b0;
      fifo_full   = 1'b0;
      host_wr     = 1'b0;
      host_addr   = '0;
      host_data   = '0;
      frame_num   = 0;
      model_armed = 1'b0;
      full_en     = 1'b0;
      full_prev   = 1'b0;
      ovf_exp     = 1'b0;
      rst_exp     = 1'b0;
      rx_word     = '0;
      rx_bits     = 0;
      repeat (5) @(posedge clk_80);
      #DRV_DLY;
      frame_valid = 1'b1;

      // Outputs quiet, sensor still in reset
      @(negedge clk_80);
      check("pix_valid", 32'(1'b0), 32'(pix_valid));
      check("overflow", 32'(1'b0), 32'(overflow));
      check("spi_en", 32'(1'b0), 32'(spi_en));
      check("spi_clk", 32'(1'b0), 32'(spi_clk));
      check("spi_dat", 32'(1'b0), 32'(spi_dat));
      check("sensor_rst_n", 32'(1'b0), 32'(sensor_rst_n));

      // Zero count sends the single default word
      exp_q.push_back(`CFG_DEFAULT);
      host_write(`HOST_AW'(`ADDR_START), `BYTE_W'(rnd(256)));
      run_config(1);

      // Random table, count 1 to 7
      for (int k = 0; k < `NUM_REGS; k++)
      begin
         a = `BYTE_W'(rnd(256));
         v = `BYTE_W'(rnd(256));
         host_write(`HOST_AW'(2 * k), a);
         host_write(`HOST_AW'(2 * k + 1), v);
         exp_tbl[k] = {a, v};
      end
      cnt = 1 + rnd(7);
      host_write(`HOST_AW'(`ADDR_COUNT), {5'(rnd(32)), `CNT_W'(cnt)});
      for (int i = 0; i < cnt; i++)
      begin
         if (i < `NUM_REGS)
         begin
            exp_q.push_back(exp_tbl[i]);
         end
         else
         begin
            exp_q.push_back(`CFG_FILL);
         end
      end
      host_write(`HOST_AW'(`ADDR_START), `BYTE_W'(rnd(256)));
      // Second start lands while busy and must be dropped
      repeat (20) @(posedge clk_80);
      host_write(`HOST_AW'(`ADDR_START), `BYTE_W'(rnd(256)));
      run_config(cnt);

      // Frames 1 to 6, only frame 1 captured
      set_open(1'b1);
      repeat (6) run_frame();
      // Re-arm, frame 9 is the next eligible one
      set_open(1'b0);
      set_open(1'b1);
      repeat (6) run_frame();
      // Overflow phase, frame 17 captured with fifo_full pulses
      full_en = 1'b1;
      set_open(1'b0);
      set_open(1'b1);
      repeat (6) run_frame();
      check("overflow", 32'(1'b1), 32'(overflow));

      $display("Simulation passed");
      $finish;
   end

endmodule

/* verilog/capture_ctrl.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module capture_ctrl
   import sensor_pkg::*;
(
   input  logic               clk_80,
   input  logic               frame_valid,
   input  logic               read_open,
   input  logic               lval,
   input  logic [`PIX_W-1:0]  data_image,
   input  logic               fifo_full,
   input  logic               sel_fval,
   input  logic               sel_rise,
   input  logic               sel_fall,
   output logic [`BYTE_W-1:0] pix_data,
   output logic               pix_valid,
   output logic               overflow
);

   capture_state_e state;

   // Write strobe, master mode qualification
   assign pix_valid = (state == CAPTURE) & lval & sel_fval;

   // Upper data bits, inverted for the host
   assign pix_data = ~data_image[`PIX_W-1 -: `BYTE_W];

   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         state <= IDLE;
      end
      else
      begin
         unique case (state)
            IDLE:
            begin
               // Host opened the read side
               if (read_open)
               begin
                  state <= ARMED;
               end
            end
            ARMED:
            begin
               if (!read_open)
               begin
                  state <= IDLE;
               end
               else if (sel_rise)
               begin
                  state <= CAPTURE;
               end
            end
            CAPTURE:
            begin
               if (!read_open)
               begin
                  state <= IDLE;
               end
               else if (sel_fall)
               begin
                  state <= DONE;
               end
            end
            DONE:
            begin
               // Wait for close before the next arming
               if (!read_open)
               begin
                  state <= IDLE;
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Sticky, cleared only by reset
   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         overflow <= 1'b0;
      end
      else if ((state == CAPTURE) && fifo_full)
      begin
         overflow <= 1'b1;
      end
   end

endmodule

/* verilog/config_table.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module config_table
   import sensor_pkg::*;
(
   input  logic                clk_80,
   input  logic                frame_valid,
   input  logic                host_wr,
   input  logic [`HOST_AW-1:0] host_addr,
   input  logic [`BYTE_W-1:0]  host_data,
   spi_cfg_if.table_side       cfg
);

   localparam int AW = `HOST_AW;

   spi_word_u         reg_tbl [`NUM_REGS];
   logic [`CNT_W-1:0] count_q;
   logic              start_q;

   assign cfg.reg_count = count_q;
   assign cfg.cfg_start = start_q;

   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         for (int k = 0; k < `NUM_REGS; k++)
         begin
            reg_tbl[k] <= '0;
         end
         count_q <= '0;
         start_q <= 1'b0;
      end
      else
      begin
         // Start pulse one cycle after the write
         // No new start while a pass is running
         start_q <= host_wr && (host_addr == AW'(`ADDR_START)) && !cfg.busy;
         if (host_wr)
         begin
            // Even address is the register, odd one its value
            for (int k = 0; k < `NUM_REGS; k++)
            begin
               if (host_addr == AW'(2 * k))
               begin
                  reg_tbl[k].fld.addr <= host_data;
               end
               if (host_addr == AW'(2 * k + 1))
               begin
                  reg_tbl[k].fld.value <= host_data;
               end
            end
            if (host_addr == AW'(`ADDR_COUNT))
            begin
               count_q <= host_data[`CNT_W-1:0];
            end
         end
      end
   end

   // Word lookup for the sender, filler past the table
   always_comb
   begin
      if (cfg.reg_idx < `CNT_W'(`NUM_REGS))
      begin
         cfg.reg_word = reg_tbl[cfg.reg_idx].raw;
      end
      else
      begin
         cfg.reg_word = `CFG_FILL;
      end
   end

endmodule

/* verilog/frame_gate.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module frame_gate
(
   input  logic clk_80,
   input  logic frame_valid,
   input  logic fval,
   output logic sel_fval,
   output logic sel_rise,
   output logic sel_fall
);

   localparam int FCNT_W = $clog2(`FRAME_DECIM);

   logic              fval_d;
   logic              fval_rise;
   logic              fval_fall;
   logic [FCNT_W-1:0] frame_cnt;
   logic [FCNT_W-1:0] cnt_inc;
   logic [FCNT_W-1:0] cnt_eff;

   // Edges against the previous sample
   assign fval_rise = fval & ~fval_d;
   assign fval_fall = ~fval & fval_d;

   // Counter wraps at FRAME_DECIM
   assign cnt_inc = (frame_cnt == FCNT_W'(`FRAME_DECIM - 1)) ? '0 : frame_cnt + FCNT_W'(1);

   // Count as it stands after this cycle's edge
   assign cnt_eff = fval_rise ? cnt_inc : frame_cnt;

   // Frame 1 after reset, then every eighth
   assign sel_fval = fval & (cnt_eff == FCNT_W'(1));

   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         fval_d    <= 1'b0;
         frame_cnt <= '0;
         sel_rise  <= 1'b0;
         sel_fall  <= 1'b0;
      end
      else
      begin
         fval_d <= fval;
         if (fval_rise)
         begin
            frame_cnt <= cnt_inc;
         end
         // Edge pulses of the selected frame only, one cycle late
         sel_rise <= fval_rise & (cnt_inc == FCNT_W'(1));
         sel_fall <= fval_fall & (frame_cnt == FCNT_W'(1));
      end
   end

endmodule

/* verilog/sensor_capture_top.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module sensor_capture_top
(
   input  logic                clk_80,
   input  logic                frame_valid,
   input  logic                fval,
   input  logic                lval,
   input  logic [`PIX_W-1:0]   data_image,
   input  logic                read_open,
   input  logic                fifo_full,
   input  logic                host_wr,
   input  logic [`HOST_AW-1:0] host_addr,
   input  logic [`BYTE_W-1:0]  host_data,
   output logic [`BYTE_W-1:0]  pix_data,
   output logic                pix_valid,
   output logic                overflow,
   output logic                spi_en,
   output logic                spi_clk,
   output logic                spi_dat,
   output logic                sensor_rst_n
);

   // Selected frame level and its edge pulses
   logic sel_fval;
   logic sel_rise;
   logic sel_fall;

   // Table to sender
   spi_cfg_if cfg_bus ();

   frame_gate i_frame_gate
   (
      .clk_80      (clk_80),
      .frame_valid (frame_valid),
      .fval        (fval),
      .sel_fval    (sel_fval),
      .sel_rise    (sel_rise),
      .sel_fall    (sel_fall)
   );

   capture_ctrl i_capture_ctrl
   (
      .clk_80      (clk_80),
      .frame_valid (frame_valid),
      .read_open   (read_open),
      .lval        (lval),
      .data_image  (data_image),
      .fifo_full   (fifo_full),
      .sel_fval    (sel_fval),
      .sel_rise    (sel_rise),
      .sel_fall    (sel_fall),
      .pix_data    (pix_data),
      .pix_valid   (pix_valid),
      .overflow    (overflow)
   );

   config_table i_config_table
   (
      .clk_80      (clk_80),
      .frame_valid (frame_valid),
      .host_wr     (host_wr),
      .host_addr   (host_addr),
      .host_data   (host_data),
      .cfg         (cfg_bus.table_side)
   );

   spi_config i_spi_config
   (
      .clk_80       (clk_80),
      .frame_valid  (frame_valid),
      .cfg          (cfg_bus.sender),
      .spi_en       (spi_en),
      .spi_clk      (spi_clk),
      .spi_dat      (spi_dat),
      .sensor_rst_n (sensor_rst_n)
   );

endmodule

/* verilog/sensor_consts.svh */
`ifndef SENSOR_CONSTS_SVH
`define SENSOR_CONSTS_SVH

// Sensor pixel bus, 10-bit LUPA style data
`define PIX_W 10

// Output pixel byte and host data byte
`define BYTE_W 8

// Host register address width
`define HOST_AW 4

// Configuration table depth and count width
`define NUM_REGS 5
`define CNT_W 3

// One frame in eight is eligible for capture
`define FRAME_DECIM 8

// SPI word length, clock divider and inter-word gap
`define SPI_W 16
`define SPI_DIV 4
`define SPI_GAP 4

// Sequencer word, activates DS and TS
`define CFG_DEFAULT 16'h4079
// Filler word for indices past the table
`define CFG_FILL 16'h40F1

// Host addresses of count and start
`define ADDR_COUNT 10
`define ADDR_START 12

`endif

/* verilog/sensor_pkg.sv */
`include "sensor_consts.svh"

package sensor_pkg;

   // Capture sequencing states
   typedef enum logic [1:0]
   {
      IDLE    = 2'd0,
      ARMED   = 2'd1,
      CAPTURE = 2'd2,
      DONE    = 2'd3
   } capture_state_e;

   // Register address in the upper byte, value in the lower
   typedef struct packed
   {
      logic [`BYTE_W-1:0] addr;
      logic [`BYTE_W-1:0] value;
   } spi_fields_t;

   // Host writes the fields, SPI sender sees the raw word
   typedef union packed
   {
      logic [`SPI_W-1:0] raw;
      spi_fields_t       fld;
   } spi_word_u;

endpackage

/* verilog/spi_cfg_if.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

interface spi_cfg_if;

   // One-cycle start request from the host side
   logic                 cfg_start;
   // Number of words, zero means one default word
   logic [`CNT_W-1:0]    reg_count;
   // Word selected by reg_idx, no latency
   logic [`SPI_W-1:0]    reg_word;
   logic [`CNT_W-1:0]    reg_idx;
   // Sender in the middle of a configuration
   logic                 busy;

   modport table_side
   (
      output cfg_start,
      output reg_count,
      output reg_word,
      input  reg_idx,
      input  busy
   );

   modport sender
   (
      input  cfg_start,
      input  reg_count,
      input  reg_word,
      output reg_idx,
      output busy
   );

endinterface

/* verilog/spi_config.sv */
`timescale 1ns/1ps
`include "sensor_consts.svh"

module spi_config
(
   input  logic      clk_80,
   input  logic      frame_valid,
   spi_cfg_if.sender cfg,
   output logic      spi_en,
   output logic      spi_clk,
   output logic      spi_dat,
   output logic      sensor_rst_n
);

   localparam int DIV_W = $clog2(`SPI_DIV);
   localparam int BIT_W = $clog2(`SPI_W);
   localparam int GAP_W = $clog2(`SPI_GAP);

   typedef enum logic [1:0]
   {
      S_IDLE,
      S_LOAD,
      S_SHIFT,
      S_GAP
   } spi_state_e;

   spi_state_e        state;
   logic [`SPI_W-1:0] shreg;
   logic [DIV_W-1:0]  div_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   logic [GAP_W-1:0]  gap_cnt;
   logic [`CNT_W-1:0] idx_q;
   logic [`CNT_W-1:0] last_idx;
   logic              use_def;
   logic              rst_done;

   assign cfg.reg_idx = idx_q;
   assign cfg.busy    = (state != S_IDLE);

   // Enable covers exactly the 16 bit periods
   assign spi_en  = (state == S_SHIFT);
   // Low first half, high second half of each bit
   assign spi_clk = spi_en & (div_cnt >= DIV_W'(`SPI_DIV / 2));
   // MSB first, zero once shifted out
   assign spi_dat = shreg[`SPI_W-1];

   // Sensor held in reset until the first pass ends
   assign sensor_rst_n = rst_done;

   always_ff @(posedge clk_80 or negedge frame_valid)
   begin
      if (!frame_valid)
      begin
         state    <= S_IDLE;
         shreg    <= '0;
         div_cnt  <= '0;
         bit_cnt  <= '0;
         gap_cnt  <= '0;
         idx_q    <= '0;
         last_idx <= '0;
         use_def  <= 1'b0;
         rst_done <= 1'b0;
      end
      else
      begin
         unique case (state)
            S_IDLE:
            begin
               // Starts while busy never reach here
               if (cfg.cfg_start)
               begin
                  idx_q    <= '0;
                  use_def  <= (cfg.reg_count == '0);
                  last_idx <= (cfg.reg_count == '0) ? '0 : cfg.reg_count - `CNT_W'(1);
                  state    <= S_LOAD;
               end
            end
            S_LOAD:
            begin
               shreg   <= use_def ? `CFG_DEFAULT : cfg.reg_word;
               div_cnt <= '0;
               bit_cnt <= '0;
               state   <= S_SHIFT;
            end
            S_SHIFT:
            begin
               div_cnt <= div_cnt + DIV_W'(1);
               // End of a bit period
               if (div_cnt == DIV_W'(`SPI_DIV - 1))
               begin
                  div_cnt <= '0;
                  shreg   <= {shreg[`SPI_W-2:0], 1'b0};
                  bit_cnt <= bit_cnt + BIT_W'(1);
                  if (bit_cnt == BIT_W'(`SPI_W - 1))
                  begin
                     if (idx_q == last_idx)
                     begin
                        // Last word of the pass
                        state    <= S_IDLE;
                        rst_done <= 1'b1;
                     end
                     else
                     begin
                        // Index moves now so the word is ready by gap end
                        idx_q   <= idx_q + `CNT_W'(1);
                        gap_cnt <= '0;
                        state   <= S_GAP;
                     end
                  end
               end
            end
            S_GAP:
            begin
               gap_cnt <= gap_cnt + GAP_W'(1);
               if (gap_cnt == GAP_W'(`SPI_GAP - 1))
               begin
                  shreg   <= cfg.reg_word;
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= S_SHIFT;
               end
            end
            default:
            begin
               state <= S_IDLE;
            end
         endcase
      end
   end

endmodule
